//--- dv/noc_checker.sv
`timescale 1ns/100ps

module noc_checker
    import noc_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         psel_i,
    input  logic         penable_i,
    input  logic         pwrite_i,
    input  logic [7:0]   paddr_i,
    input  logic [31:0]  pwdata_i,
    input  logic [31:0]  prdata_i,
    input  logic         pready_i,
    input  logic         pslverr_i,
    input  logic         is_end_i,
    input  count_t       in_cycle_i,
    input  logic [127:0] test_name_i,
    input  logic         exp_err_i,
    output int           errors_o
);

    port_t  route_m    [num_nodes * num_nodes];   // index node*4+dest
    int     qcount     [num_nodes];
    int     node_flits [num_nodes];   // flits queued per source since last start
    count_t pend       [num_nodes];   // per destination, not yet run
    count_t deliv_m    [num_nodes];
    int     run_min;
    logic   ran_m;
    logic   busy_eff;
    logic   access;
    logic   err_exp;
    int     err_cnt = 0;

    assign busy_eff = ran_m && !is_end_i;   // is_end marks the end of the run
    assign access   = psel_i && penable_i;
    assign errors_o = err_cnt;

    function automatic logic is_deliv_addr(input logic [7:0] a);
        return int'(a) >= int'(addr_delivered_base)
            && int'(a) < int'(addr_delivered_base) + 4 * num_nodes
            && a[1:0] == 2'b00;
    endfunction

    function automatic logic is_rdback_addr(input logic [7:0] a);
        return int'(a) >= int'(addr_route_rd_base)
            && int'(a) < int'(addr_route_rd_base) + 4 * num_nodes * num_nodes
            && a[1:0] == 2'b00;
    endfunction

    // error rules of the apb block
    function automatic logic expect_error();
        logic wr_mapped;
        logic rd_mapped;
        wr_mapped = paddr_i == addr_ctrl || paddr_i == addr_route || paddr_i == addr_push;
        rd_mapped = paddr_i == addr_ctrl || paddr_i == addr_cycles
            || is_deliv_addr(paddr_i) || is_rdback_addr(paddr_i);
        if (!pwrite_i)
            return !rd_mapped;
        if (!wr_mapped)
            return 1'b1;
        if (busy_eff && (paddr_i != addr_ctrl || pwdata_i[0]))
            return 1'b1;   // config frozen during a run
        return paddr_i == addr_push && qcount[pwdata_i[7:6]] >= int'(queue_depth);
    endfunction

    task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
        $display("MISMATCH %0s expected %0h actual %0h", test_name_i, expected, actual);
        err_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("checker: %0s during %0s", what, test_name_i);
        err_cnt++;
    endtask

    task automatic apply_write();
        int flits;
        int src;
        int dest;
        if (paddr_i == addr_route)
        begin
            route_m[int'(pwdata_i[5:4]) * num_nodes + int'(pwdata_i[3:2])] = pwdata_i[1:0];
        end
        else if (paddr_i == addr_push)
        begin
            src   = int'(pwdata_i[7:6]);
            dest  = int'(pwdata_i[5:4]);
            flits = (pwdata_i[3:0] == 4'd0) ? 1 : int'(pwdata_i[3:0]);   // zero means one
            qcount[src]++;
            node_flits[src] += flits;
            pend[dest] += count_t'(flits);
        end
        else if (pwdata_i[0])
        begin
            // everything queued gets delivered by the end of this run
            ran_m   = 1'b1;
            run_min = 0;
            for (int n = 0; n < num_nodes; n++)
            begin
                if (node_flits[n] > run_min)
                    run_min = node_flits[n];
                node_flits[n] = 0;
                qcount[n]     = 0;
                deliv_m[n]    = deliv_m[n] + pend[n];
                pend[n]       = '0;
            end
        end
    endtask

    task automatic check_read();
        logic [31:0] expected;
        logic        qempty;
        int          idx;
        if (busy_eff)
            return;   // counters still moving
        qempty = 1'b1;
        for (int n = 0; n < num_nodes; n++)
        begin
            if (qcount[n] != 0)
                qempty = 1'b0;
        end
        if (paddr_i == addr_ctrl)
        begin
            expected = {29'd0, qempty, ran_m, 1'b0};
        end
        else if (paddr_i == addr_cycles)
        begin
            expected = ran_m ? 32'(in_cycle_i) : 32'd0;   // register and port agree
            if (ran_m && prdata_i < 32'(run_min))
            begin
                $display("MISMATCH %0s expected at least %0d actual %0d",
                         test_name_i, run_min, prdata_i);
                err_cnt++;
            end
        end
        else if (is_deliv_addr(paddr_i))
        begin
            idx      = (int'(paddr_i) - int'(addr_delivered_base)) / 4;
            expected = 32'(deliv_m[idx]);
        end
        else
        begin
            idx      = (int'(paddr_i) - int'(addr_route_rd_base)) / 4;
            expected = 32'(route_m[idx]);
        end
        if (prdata_i !== expected)
            report_mismatch(expected, prdata_i);
    endtask

    always @(negedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int e = 0; e < num_nodes * num_nodes; e++)
                route_m[e] = port_eject;
            for (int n = 0; n < num_nodes; n++)
            begin
                qcount[n]     = 0;
                node_flits[n] = 0;
                pend[n]       = '0;
                deliv_m[n]    = '0;
            end
            run_min = 0;
            ran_m   = 1'b0;
        end
        else
        begin
            if (!ran_m && (is_end_i || in_cycle_i != '0))
                report_problem("run status is not idle before the first start");
            if (!access && pslverr_i)
                report_problem("pslverr raised outside an access phase");
            if (access)
            begin
                err_exp = expect_error();
                if (err_exp != exp_err_i)
                    report_problem("stimulus table and error rules disagree");
                if (!pready_i)
                    report_problem("pready low in the access phase");
                if (pslverr_i !== err_exp)
                    report_mismatch(32'(err_exp), 32'(pslverr_i));
                else if (!pslverr_i && pwrite_i)
                    apply_write();
                else if (!pslverr_i)
                    check_read();
            end
        end
    end

endmodule

//--- dv/noc_tb.sv
`timescale 1ns/100ps

module noc_tb
    import noc_pkg::*;
();

    typedef enum logic [1:0] {do_read, do_write, do_wait} op_e;

    logic         clk;
    logic         reset;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [7:0]   paddr;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;
    logic         is_end;
    count_t       in_cycle;
    logic [127:0] cur_name;
    logic         cur_err;
    int           errors;
    int           timeouts;

    // stimulus table, one access or wait per row
    op_e          row_op   [96];
    logic [127:0] row_name [96];
    logic [7:0]   row_addr [96];
    logic [31:0]  row_data [96];
    logic         row_err  [96];
    int           num_rows;
    logic [31:0]  seed;

    noc_sim_top i_noc_sim_top (
        .clk        (clk),
        .reset      (reset),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .is_end_o   (is_end),
        .in_cycle_o (in_cycle)
    );

    noc_checker i_noc_checker (
        .clk         (clk),
        .reset       (reset),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .pslverr_i   (pslverr),
        .is_end_i    (is_end),
        .in_cycle_i  (in_cycle),
        .test_name_i (cur_name),
        .exp_err_i   (cur_err),
        .errors_o    (errors)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic port_t shortest_port(input int node, input int dest);
        int hops;
        hops = (dest - node + num_nodes) % num_nodes;
        if (hops == 0)
            return port_eject;
        else if (hops == num_nodes - 1)
            return port_ccw;
        return port_cw;   // two hops either way, clockwise wins
    endfunction

    task automatic add_row(input logic [127:0] name, input op_e op, input logic [7:0] addr,
                           input logic [31:0] data, input logic err);
        row_name[num_rows] = name;
        row_op[num_rows]   = op;
        row_addr[num_rows] = addr;
        row_data[num_rows] = data;
        row_err[num_rows]  = err;
        num_rows++;
    endtask

    task automatic add_random_packet(input int src, input logic [127:0] name);
        seed = lcg_next(seed);
        add_row(name, do_write, addr_push,
                {24'd0, 2'(src), seed[21:20], 4'd1 + 4'(seed[17:16])}, 1'b0);
    endtask

    task automatic add_end_reads();
        add_row("end_ctrl", do_read, addr_ctrl, '0, 1'b0);
        for (int n = 0; n < num_nodes; n++)
            add_row("end_deliv", do_read, addr_delivered_base + 8'(4 * n), '0, 1'b0);
        add_row("end_cycles", do_read, addr_cycles, '0, 1'b0);
        add_row("route_kept", do_read, addr_route_rd_base + 8'd8, '0, 1'b0);  // node 0 dest 2
    endtask

    task automatic build_table();
        int extra;
        num_rows = 0;
        seed     = 32'd38015;
        add_row("reset_ctrl", do_read, addr_ctrl, '0, 1'b0);
        for (int n = 0; n < num_nodes; n++)
            add_row("reset_deliv", do_read, addr_delivered_base + 8'(4 * n), '0, 1'b0);
        add_row("reset_cycles", do_read, addr_cycles, '0, 1'b0);
        for (int n = 0; n < num_nodes; n++)
        begin
            for (int d = 0; d < num_nodes; d++)
            begin
                if (d != n)   // self entries stay eject from reset
                    add_row("route_wr", do_write, addr_route,
                            {26'd0, 2'(n), 2'(d), shortest_port(n, d)}, 1'b0);
            end
        end
        for (int e = 0; e < num_nodes * num_nodes; e++)
            add_row("route_rd", do_read, addr_route_rd_base + 8'(4 * e), '0, 1'b0);
        // long packet keeps the run busy through the error rows
        add_row("push_long", do_write, addr_push, {24'd0, 2'd0, 2'd2, 4'd4}, 1'b0);
        for (int n = 0; n < num_nodes; n++)
        begin
            seed  = lcg_next(seed);
            extra = int'(seed[16]);
            for (int k = 0; k < ((n == 0) ? 0 : 1) + extra; k++)
                add_random_packet(n, "push");
        end
        add_row("bad_rd", do_read, 8'h30, '0, 1'b1);
        add_row("bad_wr", do_write, 8'h0c, 32'd1, 1'b1);
        add_row("start", do_write, addr_ctrl, 32'd1, 1'b0);
        add_row("busy_route", do_write, addr_route, {26'd0, 2'd0, 2'd2, port_ccw}, 1'b1);
        add_row("busy_start", do_write, addr_ctrl, 32'd1, 1'b1);
        add_row("run1_end", do_wait, '0, '0, 1'b0);
        add_end_reads();
        for (int k = 0; k < int'(queue_depth); k++)
            add_random_packet(1, "fill_push");
        add_row("fifth_push", do_write, addr_push, {24'd0, 2'd1, 2'd3, 4'd1}, 1'b1);
        add_row("start2", do_write, addr_ctrl, 32'd1, 1'b0);
        add_row("run2_end", do_wait, '0, '0, 1'b0);
        add_end_reads();
    endtask

    task automatic apb_access(input int i);
        int cnt;
        @(posedge clk);
        psel     <= 1'b1;   // setup phase
        penable  <= 1'b0;
        pwrite   <= row_op[i] == do_write;
        paddr    <= row_addr[i];
        pwdata   <= row_data[i];
        cur_name <= row_name[i];
        cur_err  <= row_err[i];
        @(posedge clk);
        penable <= 1'b1;
        cnt = 0;
        do
        begin
            @(negedge clk);
            cnt++;
        end
        while (!pready && cnt < 16);
        if (!pready)
        begin
            $display("timeout: no pready for %0s", row_name[i]);
            timeouts++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_for_end(input int i);
        int cnt;
        cnt = 0;
        do
        begin
            @(negedge clk);
            cnt++;
        end
        while (!is_end && cnt < 4000);
        if (!is_end)
        begin
            $display("timeout: %0s, the run did not end within 4000 cycles", row_name[i]);
            timeouts++;
        end
    endtask

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        cur_name = '0;
        cur_err  = 1'b0;
        timeouts = 0;
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < num_rows; i++)
        begin
            if (row_op[i] == do_wait)
                wait_for_end(i);
            else
                apb_access(i);
        end
        repeat (2) @(posedge clk);
        $display("closing: %0d checker errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- filelist.f
hw/noc_pkg.sv
hw/noc_cfg_if.sv
hw/noc_inject_if.sv
hw/noc_cfg_apb.sv
hw/route_table.sv
hw/packet_source.sv
hw/flit_network.sv
hw/noc_sim_top.sv
dv/noc_checker.sv
dv/noc_tb.sv

//--- hw/flit_network.sv
`timescale 1ns/100ps

module flit_network
    import noc_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_i,
    noc_inject_if.network_side  inj,
    output node_t               lookup_dest_o [num_nodes][num_slots],
    input  port_t               lookup_port_i [num_nodes][num_slots],
    output logic                busy_o,
    output logic                is_end_o,
    output count_t              delivered_o [num_nodes],
    output count_t              cycles_o
);

    flit_t  slot_q [num_nodes][num_slots];
    flit_t  slot_d [num_nodes][num_slots];
    logic   phase_q;                       // 0 decide, 1 apply
    logic   busy_q;
    logic   is_end_q;
    count_t cycles_q;
    count_t delivered_q [num_nodes];
    count_t eject_cnt   [num_nodes];       // per destination, this step
    logic   net_empty;

    // moves decided in phase 0
    logic [num_slots-1:0] leave_d [num_nodes];
    logic [num_slots-1:0] leave_q [num_nodes];
    logic [num_slots-1:0] eject_d [num_nodes];
    logic [num_slots-1:0] eject_q [num_nodes];
    logic [num_slots-1:0] fill    [num_nodes];
    flit_t cw_out_d  [num_nodes];
    flit_t cw_out_q  [num_nodes];
    flit_t ccw_out_d [num_nodes];
    flit_t ccw_out_q [num_nodes];

    always_comb
    begin
        for (int n = 0; n < num_nodes; n++)
        begin
            for (int s = 0; s < num_slots; s++)
                lookup_dest_o[n][s] = slot_q[n][s].dest;
        end
    end

    // phase 0: route every slot, fixed priority prev > next > local per port
    always_comb
    begin
        logic  cw_free;
        logic  ccw_free;
        port_t out_port;
        for (int n = 0; n < num_nodes; n++)
        begin
            cw_free  = !slot_q[(n + 1) % num_nodes][slot_prev].valid;
            ccw_free = !slot_q[(n + num_nodes - 1) % num_nodes][slot_next].valid;
            leave_d[n]   = '0;
            eject_d[n]   = '0;
            cw_out_d[n]  = '0;
            ccw_out_d[n] = '0;
            for (int s = 0; s < num_slots; s++)
            begin
                out_port = (slot_q[n][s].dest == node_t'(n)) ? port_eject : lookup_port_i[n][s];
                if (slot_q[n][s].valid)
                begin
                    if (out_port == port_eject)
                    begin
                        eject_d[n][s] = 1'b1;     // never blocks
                        leave_d[n][s] = 1'b1;
                    end
                    else if (out_port == port_cw && cw_free)
                    begin
                        cw_out_d[n]   = slot_q[n][s];
                        leave_d[n][s] = 1'b1;
                        cw_free       = 1'b0;
                    end
                    else if (out_port == port_ccw && ccw_free)
                    begin
                        ccw_out_d[n]  = slot_q[n][s];
                        leave_d[n][s] = 1'b1;
                        ccw_free      = 1'b0;
                    end
                end
            end
        end
    end

    // injection only into a local slot empty at step start
    always_comb
    begin
        for (int n = 0; n < num_nodes; n++)
            inj.pop[n] = busy_q && phase_q && inj.head_valid[n] && !slot_q[n][slot_local].valid;
    end

    // phase 1: apply the recorded moves
    always_comb
    begin
        for (int n = 0; n < num_nodes; n++)
        begin
            fill[n] = '0;
            for (int s = 0; s < num_slots; s++)
            begin
                slot_d[n][s] = slot_q[n][s];
                if (leave_q[n][s])
                    slot_d[n][s].valid = 1'b0;
            end
        end
        for (int n = 0; n < num_nodes; n++)
        begin
            if (cw_out_q[n].valid)
            begin
                slot_d[(n + 1) % num_nodes][slot_prev] = cw_out_q[n];
                fill[(n + 1) % num_nodes][slot_prev]   = 1'b1;
            end
            if (ccw_out_q[n].valid)
            begin
                slot_d[(n + num_nodes - 1) % num_nodes][slot_next] = ccw_out_q[n];
                fill[(n + num_nodes - 1) % num_nodes][slot_next]   = 1'b1;
            end
            if (inj.pop[n])
            begin
                slot_d[n][slot_local] = {1'b1, inj.head_dest[n]};
                fill[n][slot_local]   = 1'b1;
            end
        end
    end

    always_comb
    begin
        net_empty = inj.queues_empty;
        for (int d = 0; d < num_nodes; d++)
            eject_cnt[d] = '0;
        for (int n = 0; n < num_nodes; n++)
        begin
            for (int s = 0; s < num_slots; s++)
            begin
                if (eject_q[n][s])
                    eject_cnt[slot_q[n][s].dest] = eject_cnt[slot_q[n][s].dest] + 1'b1;
                if (slot_d[n][s].valid)
                    net_empty = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase_q  <= 1'b0;
            busy_q   <= 1'b0;
            is_end_q <= 1'b0;
            cycles_q <= '0;
            for (int n = 0; n < num_nodes; n++)
            begin
                delivered_q[n] <= '0;
                for (int s = 0; s < num_slots; s++)
                    slot_q[n][s] <= '0;
            end
        end
        else if (start_i)
        begin
            busy_q   <= 1'b1;
            is_end_q <= 1'b0;
            phase_q  <= 1'b0;
            cycles_q <= '0;   // delivered counts stay cumulative
        end
        else if (busy_q && !phase_q)
        begin
            phase_q <= 1'b1;
        end
        else if (busy_q)
        begin
            phase_q  <= 1'b0;
            slot_q   <= slot_d;
            cycles_q <= cycles_q + 1'b1;
            for (int d = 0; d < num_nodes; d++)
                delivered_q[d] <= delivered_q[d] + eject_cnt[d];
            if (net_empty)
            begin
                busy_q   <= 1'b0;
                is_end_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (busy_q && !phase_q)
        begin
            leave_q   <= leave_d;
            eject_q   <= eject_d;
            cw_out_q  <= cw_out_d;
            ccw_out_q <= ccw_out_d;
        end
    end

    assign busy_o      = busy_q;
    assign is_end_o    = is_end_q;
    assign cycles_o    = cycles_q;
    assign delivered_o = delivered_q;

    // a held flit is never overwritten
    for (genvar n = 0; n < num_nodes; n++)
    begin : g_chk
        for (genvar s = 0; s < num_slots; s++)
        begin : g_slot
            assert property (@(posedge clk) disable iff (reset)
                busy_q && phase_q && fill[n][s] |-> !slot_q[n][s].valid || leave_q[n][s]);
        end
    end

endmodule

//--- hw/noc_cfg_apb.sv
`timescale 1ns/100ps

module noc_cfg_apb
    import noc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    noc_cfg_if.apb_side cfg,
    output logic        start_o,
    input  logic        busy_i,
    input  logic        is_end_i,
    input  count_t      delivered_i [num_nodes],
    input  count_t      cycles_i
);

    logic      access;
    logic      hit_ctrl;
    logic      hit_route;
    logic      hit_push;
    logic      hit_deliv;
    logic      hit_cycles;
    logic      hit_rdback;
    logic      unmapped;
    logic      busy_err;
    logic      full_err;
    logic      err;
    logic      wr_ok;
    cfg_word_u wdata;

    assign access = psel_i & penable_i;
    assign wdata  = pwdata_i;

    // address decode
    assign hit_ctrl   = paddr_i == addr_ctrl;
    assign hit_route  = paddr_i == addr_route;
    assign hit_push   = paddr_i == addr_push;
    assign hit_cycles = paddr_i == addr_cycles;
    assign hit_deliv  = (paddr_i[7:4] == addr_delivered_base[7:4]) && (paddr_i[1:0] == 2'b00);
    assign hit_rdback = (paddr_i[7:6] == addr_route_rd_base[7:6]) && (paddr_i[1:0] == 2'b00);

    // writable and readable windows differ
    assign unmapped = pwrite_i ? !(hit_ctrl | hit_route | hit_push)
                               : !(hit_ctrl | hit_deliv | hit_cycles | hit_rdback);

    // no config changes and no restart mid run
    assign busy_err = pwrite_i & busy_i & (hit_route | hit_push | (hit_ctrl & pwdata_i[0]));
    assign full_err = pwrite_i & hit_push & cfg.queue_full[wdata.packet.src];

    assign err   = access & (unmapped | busy_err | full_err);
    assign wr_ok = access & pwrite_i & ~err;

    assign pready_o  = access;   // zero wait states
    assign pslverr_o = err;

    assign cfg.route_we = wr_ok & hit_route;
    assign cfg.push_we  = wr_ok & hit_push;
    assign cfg.cfg_word = wdata;
    assign start_o      = wr_ok & hit_ctrl & pwdata_i[0];

    // entry index is node*4+dest
    assign cfg.rd_node = paddr_i[5:4];
    assign cfg.rd_dest = paddr_i[3:2];

    always_comb
    begin
        prdata_o = '0;
        if (hit_ctrl)
            prdata_o = {29'd0, cfg.queues_empty, is_end_i, busy_i};
        else if (hit_deliv)
            prdata_o = 32'(delivered_i[paddr_i[3:2]]);
        else if (hit_cycles)
            prdata_o = 32'(cycles_i);
        else if (hit_rdback)
            prdata_o = 32'(cfg.rd_port);
    end

    // access phase always follows a selected setup phase
    assert property (@(posedge clk) disable iff (reset) penable_i |-> psel_i);

endmodule

//--- hw/noc_cfg_if.sv
`timescale 1ns/100ps

interface noc_cfg_if
    import noc_pkg::*;
();

    logic                 route_we;
    logic                 push_we;
    cfg_word_u            cfg_word;
    node_t                rd_node;      // route readback select
    node_t                rd_dest;
    port_t                rd_port;
    logic [num_nodes-1:0] queue_full;
    logic                 queues_empty;

    modport apb_side (
        output route_we, push_we, cfg_word, rd_node, rd_dest,
        input  rd_port, queue_full, queues_empty
    );

    modport table_side (
        input  route_we, cfg_word, rd_node, rd_dest,
        output rd_port
    );

    modport source_side (
        input  push_we, cfg_word,
        output queue_full, queues_empty
    );

endinterface

//--- hw/noc_inject_if.sv
`timescale 1ns/100ps

interface noc_inject_if
    import noc_pkg::*;
();

    logic [num_nodes-1:0] head_valid;
    node_t                head_dest [num_nodes];
    logic                 queues_empty;
    logic [num_nodes-1:0] pop;          // one flit taken per pulse

    modport source_side (
        output head_valid, head_dest, queues_empty,
        input  pop
    );

    modport network_side (
        input  head_valid, head_dest, queues_empty,
        output pop
    );

endinterface

//--- hw/noc_pkg.sv
package noc_pkg;

    // ring geometry
    localparam int num_nodes = 4;
    localparam int num_slots = 3;
    localparam int slot_prev  = 0;   // flit arriving from node-1
    localparam int slot_next  = 1;   // flit arriving from node+1
    localparam int slot_local = 2;   // injected flit

    typedef logic [1:0]  node_t;
    typedef logic [1:0]  port_t;
    typedef logic [3:0]  flit_cnt_t;  // zero counts as one flit
    typedef logic [15:0] count_t;
    typedef logic [1:0]  qptr_t;
    typedef logic [2:0]  qcnt_t;

    localparam qcnt_t queue_depth = 3'd4;

    localparam port_t port_eject = 2'd0;
    localparam port_t port_cw    = 2'd1;  // towards node+1
    localparam port_t port_ccw   = 2'd2;  // towards node-1

    typedef struct packed {
        logic  valid;
        node_t dest;
    } flit_t;

    typedef struct packed {
        logic [25:0] rsvd;
        node_t       node;
        node_t       dest;
        port_t       port;
    } route_entry_t;

    typedef struct packed {
        logic [23:0] rsvd;
        node_t       src;
        node_t       dest;
        flit_cnt_t   flits;
    } packet_entry_t;

    // one apb write word, meaning depends on the address written
    typedef union packed {
        route_entry_t  route;
        packet_entry_t packet;
    } cfg_word_u;

    localparam logic [7:0] addr_ctrl           = 8'h00;
    localparam logic [7:0] addr_route          = 8'h04;
    localparam logic [7:0] addr_push           = 8'h08;
    localparam logic [7:0] addr_delivered_base = 8'h10;
    localparam logic [7:0] addr_cycles         = 8'h20;
    localparam logic [7:0] addr_route_rd_base  = 8'h40;

endpackage

//--- hw/noc_sim_top.sv
`timescale 1ns/100ps

module noc_sim_top
    import noc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        is_end_o,
    output count_t      in_cycle_o
);

    noc_cfg_if    cfg_if ();
    noc_inject_if inj_if ();

    logic   start;
    logic   busy;
    logic   is_end;
    count_t cycles;
    count_t delivered   [num_nodes];
    node_t  lookup_dest [num_nodes][num_slots];
    port_t  lookup_port [num_nodes][num_slots];

    noc_cfg_apb i_noc_cfg_apb (
        .clk         (clk),
        .reset       (reset),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .cfg         (cfg_if.apb_side),
        .start_o     (start),
        .busy_i      (busy),
        .is_end_i    (is_end),
        .delivered_i (delivered),
        .cycles_i    (cycles)
    );

    route_table i_route_table (
        .clk           (clk),
        .reset         (reset),
        .cfg           (cfg_if.table_side),
        .lookup_dest_i (lookup_dest),
        .lookup_port_o (lookup_port)
    );

    packet_source i_packet_source (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg_if.source_side),
        .inj   (inj_if.source_side)
    );

    flit_network i_flit_network (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start),
        .inj           (inj_if.network_side),
        .lookup_dest_o (lookup_dest),
        .lookup_port_i (lookup_port),
        .busy_o        (busy),
        .is_end_o      (is_end),
        .delivered_o   (delivered),
        .cycles_o      (cycles)
    );

    assign is_end_o   = is_end;
    assign in_cycle_o = cycles;

endmodule

//--- hw/packet_source.sv
`timescale 1ns/100ps

module packet_source
    import noc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    noc_cfg_if.source_side    cfg,
    noc_inject_if.source_side inj
);

    node_t     q_dest   [num_nodes][queue_depth];
    flit_cnt_t q_flits  [num_nodes][queue_depth];
    qptr_t     wr_ptr   [num_nodes];
    qptr_t     rd_ptr   [num_nodes];
    qcnt_t     count    [num_nodes];
    flit_cnt_t sent     [num_nodes];   // flits of head packet already popped
    flit_cnt_t head_len [num_nodes];
    logic [num_nodes-1:0] push;
    logic [num_nodes-1:0] retire;
    logic                 all_empty;

    always_comb
    begin
        all_empty = 1'b1;
        for (int n = 0; n < num_nodes; n++)
        begin
            push[n] = cfg.push_we && (cfg.cfg_word.packet.src == node_t'(n));
            head_len[n] = (q_flits[n][rd_ptr[n]] == '0) ? flit_cnt_t'(1) : q_flits[n][rd_ptr[n]];
            retire[n] = inj.pop[n] && (sent[n] + 1'b1 == head_len[n]);   // last flit
            inj.head_valid[n] = count[n] != '0;
            inj.head_dest[n] = q_dest[n][rd_ptr[n]];
            cfg.queue_full[n] = count[n] == queue_depth;
            if (count[n] != '0)
                all_empty = 1'b0;
        end
    end

    assign inj.queues_empty = all_empty;
    assign cfg.queues_empty = all_empty;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int n = 0; n < num_nodes; n++)
            begin
                wr_ptr[n] <= '0;
                rd_ptr[n] <= '0;
                count[n]  <= '0;
                sent[n]   <= '0;
            end
        end
        else
        begin
            for (int n = 0; n < num_nodes; n++)
            begin
                if (push[n])
                    wr_ptr[n] <= wr_ptr[n] + 1'b1;
                if (retire[n])
                begin
                    rd_ptr[n] <= rd_ptr[n] + 1'b1;
                    sent[n]   <= '0;
                end
                else if (inj.pop[n])
                begin
                    sent[n] <= sent[n] + 1'b1;
                end
                count[n] <= count[n] + qcnt_t'(push[n]) - qcnt_t'(retire[n]);
            end
        end
    end

    // packet storage
    always_ff @(posedge clk)
    begin
        for (int n = 0; n < num_nodes; n++)
        begin
            if (push[n])
            begin
                q_dest[n][wr_ptr[n]]  <= cfg.cfg_word.packet.dest;
                q_flits[n][wr_ptr[n]] <= cfg.cfg_word.packet.flits;
            end
        end
    end

    // apb side must filter pushes to a full queue
    assert property (@(posedge clk) disable iff (reset)
        cfg.push_we |-> !cfg.queue_full[cfg.cfg_word.packet.src]);

endmodule

//--- hw/route_table.sv
`timescale 1ns/100ps

module route_table
    import noc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    noc_cfg_if.table_side cfg,
    input  node_t         lookup_dest_i [num_nodes][num_slots],
    output port_t         lookup_port_o [num_nodes][num_slots]
);

    port_t table_q [num_nodes][num_nodes];   // [node][dest]

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int n = 0; n < num_nodes; n++)
            begin
                for (int d = 0; d < num_nodes; d++)
                    table_q[n][d] <= port_eject;
            end
        end
        else if (cfg.route_we)
        begin
            table_q[cfg.cfg_word.route.node][cfg.cfg_word.route.dest] <= cfg.cfg_word.route.port;
        end
    end

    // one lookup per slot, no latency
    always_comb
    begin
        for (int n = 0; n < num_nodes; n++)
        begin
            for (int s = 0; s < num_slots; s++)
                lookup_port_o[n][s] = table_q[n][lookup_dest_i[n][s]];
        end
    end

    assign cfg.rd_port = table_q[cfg.rd_node][cfg.rd_dest];

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module noc_tb -f filelist.f -o noc_sim &&
./obj_dir/noc_sim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "simulation run: pass" ||
{ echo "simulation run: fail"; exit 1; }
